// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int ADDR_W = 16;

  typedef logic [7:0] byte_t;

  // Register index, 0 is A through 3 is D
  typedef logic [1:0] reg_idx_t;

  // Unlisted encodings run as NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_MOV  = 4'd1,
    OP_ADD  = 4'd2,
    OP_SUB  = 4'd3,
    OP_AND  = 4'd4,
    OP_OR   = 4'd5,
    OP_XOR  = 4'd6,
    OP_ADC  = 4'd7,
    OP_LDI  = 4'd8,
    OP_HALT = 4'd15
  } opcode_e;

  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t dst;
    reg_idx_t src;
  } instr_t;

  // A fetched byte is either an opcode byte or the constant after LDI
  typedef union packed {
    instr_t instr;
    byte_t  data;
  } fetch_word_u;

  typedef enum logic [2:0] {
    ALU_PASS,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_ADC
  } alu_op_e;

  typedef struct packed {
    logic       spare_hi;
    logic       halt;
    logic [3:0] spare_mid;
    logic       negative;
    logic       carry;
  } flags_t;

  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    logic     write_en;
    logic     set_flags;
    logic     halt;
    reg_idx_t dst;
    byte_t    lhs;
    byte_t    rhs;
  } exec_ctrl_t;

  typedef struct packed {
    logic     write_en;
    reg_idx_t dst;
    byte_t    data;
  } writeback_t;

endpackage

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::byte_t   lhs,
  input  cpu_pkg::byte_t   rhs,
  input  logic             carry_in,
  output cpu_pkg::byte_t   result,
  output logic             carry_out
);

  import cpu_pkg::*;

  byte_t      add_rhs;
  logic       add_cin;
  logic [8:0] sum;

  // One adder serves ADD, ADC and SUB
  always_comb begin
    add_rhs = rhs;
    add_cin = 1'b0;
    if (op == ALU_SUB) begin
      // Two's complement subtract, carry set means no borrow
      add_rhs = ~rhs;
      add_cin = 1'b1;
    end else if (op == ALU_ADC) begin
      add_cin = carry_in;
    end
    sum = {1'b0, lhs} + {1'b0, add_rhs} + {8'd0, add_cin};
  end

  always_comb begin
    result    = rhs;
    carry_out = 1'b0;
    case (op)
      ALU_ADD, ALU_SUB, ALU_ADC: begin
        result    = sum[7:0];
        carry_out = sum[8];
      end
      ALU_AND: result = lhs & rhs;
      ALU_OR:  result = lhs | rhs;
      ALU_XOR: result = lhs ^ rhs;
      default: result = rhs;
    endcase
  end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
  parameter int ADDR_W = cpu_pkg::ADDR_W
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                halt,
  output logic [ADDR_W-1:0]   mem_addr,
  input  cpu_pkg::byte_t      mem_data,
  output cpu_pkg::fetch_word_u fetch_word,
  output logic                fetch_valid
);

  logic [ADDR_W-1:0] pc;

  assign mem_addr = pc;

  // One byte per cycle, everything freezes once the machine halts
  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= '0;
      fetch_word  <= '0;
      fetch_valid <= 1'b0;
    end else if (!halt) begin
      pc              <= pc + 1'b1;
      fetch_word.data <= mem_data;
      // Marks the register as holding a real byte from the program
      fetch_valid     <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  cpu_pkg::reg_idx_t       rd_idx_a,
  input  cpu_pkg::reg_idx_t       rd_idx_b,
  output cpu_pkg::byte_t          rd_data_a,
  output cpu_pkg::byte_t          rd_data_b,
  input  cpu_pkg::writeback_t     wb,
  output cpu_pkg::byte_t [3:0]    regs
);

  // Plain muxes in place of the old tri-state buses
  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '0;
    end else if (wb.write_en) begin
      regs[wb.dst] <= wb.data;
    end
  end

endmodule

`default_nettype wire

// File: src/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 halt,
  input  cpu_pkg::fetch_word_u fetch_word,
  input  logic                 fetch_valid,
  output cpu_pkg::reg_idx_t    rd_idx_a,
  output cpu_pkg::reg_idx_t    rd_idx_b,
  input  cpu_pkg::byte_t       rd_data_a,
  input  cpu_pkg::byte_t       rd_data_b,
  input  cpu_pkg::writeback_t  wb,
  output cpu_pkg::exec_ctrl_t  ctrl
);

  import cpu_pkg::*;

  instr_t     instr;
  byte_t      lhs_fwd;
  byte_t      rhs_fwd;
  exec_ctrl_t ctrl_next;
  logic       ldi_start;
  logic       const_pending;
  reg_idx_t   const_dst;

  assign instr    = fetch_word.instr;
  assign rd_idx_a = instr.dst;
  assign rd_idx_b = instr.src;

  // Result committing this cycle overrides the value still in the register file
  always_comb begin
    lhs_fwd = rd_data_a;
    rhs_fwd = rd_data_b;
    if (wb.write_en && wb.dst == rd_idx_a) begin
      lhs_fwd = wb.data;
    end
    if (wb.write_en && wb.dst == rd_idx_b) begin
      rhs_fwd = wb.data;
    end
  end

  always_comb begin
    ctrl_next     = '0;
    ctrl_next.dst = instr.dst;
    ctrl_next.lhs = lhs_fwd;
    ctrl_next.rhs = rhs_fwd;
    ldi_start     = 1'b0;
    if (fetch_valid) begin
      ctrl_next.valid = 1'b1;
      if (const_pending) begin
        // Second byte of LDI, read as data
        ctrl_next.alu_op   = ALU_PASS;
        ctrl_next.write_en = 1'b1;
        ctrl_next.dst      = const_dst;
        ctrl_next.rhs      = fetch_word.data;
      end else begin
        case (instr.opcode)
          OP_MOV: begin
            ctrl_next.alu_op   = ALU_PASS;
            ctrl_next.write_en = 1'b1;
          end
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADC: begin
            ctrl_next.write_en  = 1'b1;
            ctrl_next.set_flags = 1'b1;
            case (instr.opcode)
              OP_ADD:  ctrl_next.alu_op = ALU_ADD;
              OP_SUB:  ctrl_next.alu_op = ALU_SUB;
              OP_AND:  ctrl_next.alu_op = ALU_AND;
              OP_OR:   ctrl_next.alu_op = ALU_OR;
              OP_XOR:  ctrl_next.alu_op = ALU_XOR;
              default: ctrl_next.alu_op = ALU_ADC;
            endcase
          end
          OP_LDI: begin
            // Bubble while the constant is fetched
            ctrl_next.valid = 1'b0;
            ldi_start       = 1'b1;
          end
          OP_HALT: ctrl_next.halt = 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl          <= '0;
      const_pending <= 1'b0;
    end else if (!halt) begin
      ctrl <= ctrl_next;
      if (fetch_valid) begin
        const_pending <= ldi_start;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!halt && ldi_start) begin
      const_dst <= instr.dst;
    end
  end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  logic                clk,
  input  logic                rst,
  input  cpu_pkg::exec_ctrl_t ctrl,
  output cpu_pkg::writeback_t wb,
  output cpu_pkg::flags_t     flags
);

  import cpu_pkg::*;

  byte_t alu_result;
  logic  alu_carry;
  logic  commit;

  alu alu_i (
    .op        (ctrl.alu_op),
    .lhs       (ctrl.lhs),
    .rhs       (ctrl.rhs),
    .carry_in  (flags.carry),
    .result    (alu_result),
    .carry_out (alu_carry)
  );

  // Nothing commits after halt, so younger instructions in flight are dropped
  assign commit = ctrl.valid && !flags.halt;

  always_comb begin
    wb.write_en = commit && ctrl.write_en;
    wb.dst      = ctrl.dst;
    wb.data     = alu_result;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (commit) begin
      if (ctrl.set_flags) begin
        flags.carry    <= alu_carry;
        flags.negative <= alu_result[7];
      end
      // Sticky until reset
      if (ctrl.halt) begin
        flags.halt <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
  parameter int ADDR_W = cpu_pkg::ADDR_W
) (
  input  logic              clk,
  input  logic              rst,
  output logic [ADDR_W-1:0] mem_addr,
  input  cpu_pkg::byte_t    mem_data,
  output cpu_pkg::byte_t    a,
  output cpu_pkg::byte_t    b,
  output cpu_pkg::byte_t    c,
  output cpu_pkg::byte_t    d,
  output cpu_pkg::flags_t   flags,
  output logic              halt
);

  import cpu_pkg::*;

  fetch_word_u     fetch_word;
  logic            fetch_valid;
  reg_idx_t        rd_idx_a;
  reg_idx_t        rd_idx_b;
  byte_t           rd_data_a;
  byte_t           rd_data_b;
  byte_t [3:0]     regs;
  exec_ctrl_t      ctrl;
  writeback_t      wb;

  // Halt level comes straight from the flags register
  assign halt = flags.halt;

  assign a = regs[0];
  assign b = regs[1];
  assign c = regs[2];
  assign d = regs[3];

  fetch_unit #(.ADDR_W(ADDR_W)) fetch_i (
    .clk         (clk),
    .rst         (rst),
    .halt        (halt),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .fetch_word  (fetch_word),
    .fetch_valid (fetch_valid)
  );

  instr_decode decode_i (
    .clk         (clk),
    .rst         (rst),
    .halt        (halt),
    .fetch_word  (fetch_word),
    .fetch_valid (fetch_valid),
    .rd_idx_a    (rd_idx_a),
    .rd_idx_b    (rd_idx_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .wb          (wb),
    .ctrl        (ctrl)
  );

  reg_file regs_i (
    .clk       (clk),
    .rst       (rst),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wb        (wb),
    .regs      (regs)
  );

  execute_stage execute_i (
    .clk   (clk),
    .rst   (rst),
    .ctrl  (ctrl),
    .wb    (wb),
    .flags (flags)
  );

endmodule

`default_nettype wire

// File: tb/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

  import cpu_pkg::*;

  localparam int HALT_TIMEOUT = 500;
  localparam reg_idx_t RA = 2'd0;
  localparam reg_idx_t RB = 2'd1;
  localparam reg_idx_t RC = 2'd2;
  localparam reg_idx_t RD = 2'd3;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] mem_addr;
  byte_t             mem_data;
  byte_t             a;
  byte_t             b;
  byte_t             c;
  byte_t             d;
  flags_t            flags;
  logic              halt;

  // Program memory and the byte list each test builds before loading it
  byte_t prog [256];
  byte_t code [$];

  // Predicted state from the reference model
  byte_t  model_regs [4];
  flags_t model_flags;
  int     halt_pc;
  int     fail_count;
  int     seed;

  cpu_top #(.ADDR_W(ADDR_W)) dut_i (
    .clk      (clk),
    .rst      (rst),
    .mem_addr (mem_addr),
    .mem_data (mem_data),
    .a        (a),
    .b        (b),
    .c        (c),
    .d        (d),
    .flags    (flags),
    .halt     (halt)
  );

  always #2 clk = ~clk;

  // Combinational memory model updated away from the rising edge
  always @(negedge clk) begin
    mem_data <= prog[mem_addr[7:0]];
  end

  task automatic stop_on_failure;
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_count++;
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  function automatic byte_t encode(input opcode_e op, input reg_idx_t dst, input reg_idx_t src);
    return {op, dst, src};
  endfunction

  task automatic add_instr(input opcode_e op, input reg_idx_t dst, input reg_idx_t src);
    code.push_back(encode(op, dst, src));
  endtask

  task automatic add_ldi(input reg_idx_t dst, input byte_t value);
    code.push_back(encode(OP_LDI, dst, 2'd0));
    code.push_back(value);
  endtask

  task automatic load_memory;
    for (int i = 0; i < 256; i++) begin
      prog[i] = (i < code.size()) ? code[i] : (8'(i) ^ 8'ha5);
    end
  endtask

  // Sequential interpreter of the instruction set that runs one instruction at a time
  task automatic run_model;
    int         pc;
    byte_t      w;
    byte_t      lhs;
    byte_t      rhs;
    logic [8:0] sum;
    opcode_e    op;
    reg_idx_t   dst;
    reg_idx_t   src;
    logic       is_alu;
    logic       done;
    model_flags = '0;
    for (int i = 0; i < 4; i++) begin
      model_regs[i] = 8'h00;
    end
    pc = 0;
    done = 1'b0;
    while (!done && pc <= 255) begin
      w = prog[pc];
      op = opcode_e'(w[7:4]);
      dst = w[3:2];
      src = w[1:0];
      lhs = model_regs[dst];
      rhs = model_regs[src];
      sum = '0;
      is_alu = 1'b1;
      case (op)
        OP_ADD: sum = {1'b0, lhs} + {1'b0, rhs};
        OP_ADC: sum = {1'b0, lhs} + {1'b0, rhs} + {8'd0, model_flags.carry};
        OP_SUB: sum = {1'b0, lhs} + {1'b0, ~rhs} + 9'd1;
        OP_AND: sum = {1'b0, lhs & rhs};
        OP_OR:  sum = {1'b0, lhs | rhs};
        OP_XOR: sum = {1'b0, lhs ^ rhs};
        default: is_alu = 1'b0;
      endcase
      if (is_alu) begin
        model_regs[dst] = sum[7:0];
        model_flags.carry = sum[8];
        model_flags.negative = sum[7];
      end else begin
        case (op)
          OP_MOV: model_regs[dst] = rhs;
          OP_LDI: begin
            pc++;
            model_regs[dst] = prog[pc];
          end
          OP_HALT: begin
            model_flags.halt = 1'b1;
            halt_pc = pc;
            done = 1'b1;
          end
          default: ;
        endcase
      end
      pc++;
    end
    if (!done) begin
      $display("Reference model reached the end of memory without a HALT");
      stop_on_failure();
    end
  endtask

  // Also checks the reset values before the first edge of the run
  task automatic reset_dut;
    @(negedge clk);
    rst <= 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_addr("mem_addr", mem_addr, '0);
    check_byte("a", a, 8'h00);
    check_byte("b", b, 8'h00);
    check_byte("c", c, 8'h00);
    check_byte("d", d, 8'h00);
    check_flags("flags", flags, '0);
    check_level("halt", halt, 1'b0);
    rst <= 1'b0;
  endtask

  task automatic wait_halt;
    int cycles;
    cycles = 0;
    while (halt !== 1'b1) begin
      if (cycles >= HALT_TIMEOUT) begin
        $display("Timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
        stop_on_failure();
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic check_state;
    check_byte("a", a, model_regs[0]);
    check_byte("b", b, model_regs[1]);
    check_byte("c", c, model_regs[2]);
    check_byte("d", d, model_regs[3]);
    check_flags("flags", flags, model_flags);
    check_level("halt", halt, 1'b1);
    check_addr("mem_addr", mem_addr, ADDR_W'(halt_pc + 3));
  endtask

  task automatic run_program;
    load_memory();
    run_model();
    reset_dut();
    wait_halt();
    check_state();
  endtask

  task automatic check_reset;
    code.delete();
    add_instr(OP_HALT, RA, RA);
    run_program();
  endtask

  task automatic load_and_move;
    code.delete();
    add_ldi(RA, 8'h11);
    add_ldi(RB, 8'h22);
    add_ldi(RC, 8'h33);
    add_ldi(RD, 8'hf4);
    add_instr(OP_MOV, RA, RD);
    add_instr(OP_MOV, RD, RB);
    add_instr(OP_MOV, RB, RC);
    add_instr(OP_MOV, RC, RA);
    add_instr(OP_HALT, RA, RA);
    run_program();
  endtask

  // Each ADD reads the result of the one just before it
  task automatic dependent_alu;
    code.delete();
    add_ldi(RA, 8'h81);
    add_instr(OP_ADD, RA, RA);
    add_instr(OP_ADD, RA, RA);
    add_instr(OP_ADD, RA, RA);
    add_ldi(RB, 8'h40);
    add_instr(OP_ADD, RB, RB);
    add_instr(OP_ADD, RB, RA);
    add_instr(OP_SUB, RA, RB);
    add_instr(OP_XOR, RC, RA);
    add_instr(OP_OR, RD, RC);
    add_instr(OP_AND, RD, RB);
    add_instr(OP_HALT, RA, RA);
    run_program();
  endtask

  task automatic carry_chain;
    code.delete();
    // 0x12f0 plus 0x0135 with the low bytes added first
    add_ldi(RA, 8'hf0);
    add_ldi(RB, 8'h12);
    add_ldi(RC, 8'h35);
    add_ldi(RD, 8'h01);
    add_instr(OP_ADD, RA, RC);
    add_instr(OP_ADC, RB, RD);
    add_ldi(RC, 8'h10);
    add_instr(OP_SUB, RC, RD);
    add_instr(OP_ADC, RA, RB);
    add_instr(OP_SUB, RD, RC);
    add_instr(OP_HALT, RA, RA);
    run_program();
  endtask

  task automatic halt_freeze;
    code.delete();
    add_ldi(RA, 8'h5a);
    add_instr(OP_ADD, RA, RA);
    add_instr(OP_HALT, RA, RA);
    // One-byte instruction right behind HALT that execute must drop
    add_instr(OP_ADD, RB, RA);
    add_ldi(RA, 8'h01);
    add_ldi(RB, 8'h02);
    add_ldi(RC, 8'h03);
    add_ldi(RD, 8'h04);
    run_program();
    repeat (20) @(negedge clk);
    check_state();
  endtask

  task automatic random_program;
    logic [31:0] r;
    logic [3:0]  op_val;
    code.delete();
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      if (r[2:0] == 3'd7) begin
        add_ldi(r[4:3], r[15:8]);
      end else begin
        // Values 0 to 6 map onto MOV through ADC
        op_val = {1'b0, r[2:0]} + 4'd1;
        add_instr(opcode_e'(op_val), r[4:3], r[6:5]);
      end
    end
    add_instr(OP_HALT, RA, RA);
    run_program();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    mem_data = 8'h00;
    fail_count = 0;
    halt_pc = 0;
    seed = 32'hf5d0;
    for (int i = 0; i < 256; i++) begin
      prog[i] = 8'h00;
    end
    check_reset();
    load_and_move();
    dependent_alu();
    carry_chain();
    halt_freeze();
    random_program();
    if (fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
src/cpu_pkg.sv
src/alu.sv
src/fetch_unit.sv
src/reg_file.sv
src/instr_decode.sv
src/execute_stage.sv
src/cpu_top.sv
tb/tb_cpu.sv

// File: Makefile
TOP = tb_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
